// File: src/mvu_pkg.sv
// MVU bit-serial dot product package
// Widths, bank geometry, pipeline latency and FSM state codes shared
// by the bit-plane dot product engine.

package mvu_pkg;

    // Vector and bank geometry
    localparam int N_LANES     = 8;                 // Vector elements, also bank word width
    localparam int BANK_DEPTH  = 64;                // Words per bank
    localparam int BANK_ADDR_W = 6;                 // Bank address width

    // Operand precision and accumulation
    localparam int PREC_W      = 4;                 // Precision field, holds bits minus 1
    localparam int SHIFT_W     = 5;                 // Sum of two bit positions, up to 30
    localparam int CNT_W       = 4;                 // Popcount of N_LANES bits
    localparam int ACC_W       = 32;                // Accumulator width

    // Pipeline
    localparam int MEM_RD_LATENCY = 1;              // Bank read latency in cycles
    localparam int CTRL_FLAGS_W   = 1 + SHIFT_W + 2; // {neg, shift, valid, last}

    // Job FSM encoding
    localparam int         ST_W     = 2;
    localparam logic [1:0] ST_IDLE  = 2'd0;         // Waiting for start
    localparam logic [1:0] ST_RUN   = 2'd1;         // One bit-plane pair per cycle
    localparam logic [1:0] ST_DRAIN = 2'd2;         // Pipeline emptying

endpackage

// File: src/mvu_controller.sv
// MVU job controller
// Accepts start when idle, pulses cfg_load, enables the address walk for
// one pair per cycle, then waits for the accumulator to drain and raises
// done and irq. irq stays up until the next job is accepted.

`timescale 1ns/1ns

module mvu_controller import mvu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,                             // Job request
    input  logic agu_last,                          // Final pair on the AGU
    input  logic acc_done,                          // Final term accumulated
    output logic cfg_load,                          // Latch config, clear counters
    output logic agu_en,                            // Address walk enable
    output logic busy,
    output logic done,
    output logic irq
);

    logic [ST_W-1:0] state;
    logic            accept;                        // Start taken this edge
    logic            finish;                        // Last term seen in DRAIN

    assign accept = start & ~busy;                  // Starts during a job are dropped
    assign finish = (state == ST_DRAIN) & acc_done;
    assign agu_en = (state == ST_RUN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            cfg_load <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            irq      <= 1'b0;
        end else begin
            cfg_load <= accept;
            done     <= finish;
            case (state)
                ST_IDLE:  if (cfg_load) state <= ST_RUN;   // Config is valid from here
                ST_RUN:   if (agu_last) state <= ST_DRAIN;
                ST_DRAIN: if (done) state <= ST_IDLE;      // Hold DRAIN through done
                default:  state <= ST_IDLE;
            endcase
            if (accept) begin
                busy <= 1'b1;
                irq  <= 1'b0;                       // New job acknowledges irq
            end else if (finish) begin
                busy <= 1'b0;
                irq  <= 1'b1;                       // Rises together with done
            end
        end
    end

    // The done pulse belongs to the tail of a job
    a_done_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (state == ST_DRAIN) && !busy);

    // Address walk only inside an accepted job
    a_run_busy: assert property (@(posedge clk) disable iff (!rst_n)
        agu_en |-> busy && !done);

endmodule

// File: src/mvu_agu.sv
// Bit-plane address generator
// Walks every weight-bit and input-bit pair, weight bit outer, both from
// bit 0. Gives both bank read addresses, the MSB flags, the combined
// shift amount and a flag on the final pair.

`timescale 1ns/1ns

module mvu_agu import mvu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,            // Restart at bit 0
    input  logic                   en,              // Step one pair
    input  logic [PREC_W-1:0]      wprec,           // Weight bits minus 1
    input  logic [PREC_W-1:0]      iprec,           // Input bits minus 1
    input  logic [BANK_ADDR_W-1:0] wbase,
    input  logic [BANK_ADDR_W-1:0] ibase,
    output logic [BANK_ADDR_W-1:0] waddr,
    output logic [BANK_ADDR_W-1:0] iaddr,
    output logic                   w_msb,
    output logic                   i_msb,
    output logic                   last,
    output logic [SHIFT_W-1:0]     shift
);

    logic [PREC_W-1:0] wbit;                        // Weight bit position, outer
    logic [PREC_W-1:0] ibit;                        // Input bit position, inner
    logic              walk_over;                   // Final pair already issued

    assign w_msb = (wbit == wprec);
    assign i_msb = (ibit == iprec);                 // Also the inner wrap point
    assign last  = w_msb & i_msb;
    assign waddr = wbase + BANK_ADDR_W'(wbit);      // Plane b sits at base+b
    assign iaddr = ibase + BANK_ADDR_W'(ibit);
    assign shift = SHIFT_W'(wbit) + SHIFT_W'(ibit); // Weight of this partial product

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wbit <= '0;
            ibit <= '0;
        end else if (load) begin
            wbit <= '0;
            ibit <= '0;
        end else if (en) begin
            if (i_msb) begin
                ibit <= '0;
                wbit <= w_msb ? '0 : wbit + 1'b1;   // Wraps back after the last pair
            end else begin
                ibit <= ibit + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || load) begin
            walk_over <= 1'b0;
        end else if (en && last) begin
            walk_over <= 1'b1;
        end
    end

    // Controller must stop the walk on the final pair
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        walk_over |-> !en);

endmodule

// File: src/bitplane_bank.sv
// Bit-plane memory bank
// One word per bit-plane, bit k of a word belongs to vector element k.
// Synchronous write port and a registered read port.

`timescale 1ns/1ns

module bitplane_bank import mvu_pkg::*; (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic [BANK_ADDR_W-1:0] wr_addr,
    input  logic [BANK_ADDR_W-1:0] rd_addr,
    input  logic [N_LANES-1:0]     wr_word,
    output logic [N_LANES-1:0]     rd_word          // Valid one cycle after rd_addr
);

    logic [N_LANES-1:0] mem [BANK_DEPTH];           // Bit-plane storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        rd_word <= mem[rd_addr];                    // Read-before-write on a collision
    end

endmodule

// File: src/ctrl_delay.sv
// Control flag delay line
// Carries the per-pair flags alongside the bank read so they meet the
// read data in the same cycle. Several pairs are in flight at once.

`timescale 1ns/1ns

module ctrl_delay import mvu_pkg::*; #(
    parameter int DEPTH = 1                         // Stages, 1 or more
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [CTRL_FLAGS_W-1:0] in_flags,
    output logic [CTRL_FLAGS_W-1:0] out_flags
);

    logic [CTRL_FLAGS_W-1:0] stage [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;                     // No stray valid after reset
            end
        end else begin
            stage[0] <= in_flags;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out_flags = stage[DEPTH-1];

endmodule

// File: src/vvp_shacc.sv
// Vector-vector bit product with shift-accumulate
// Stage one ANDs a data plane with a weight plane and counts the ones.
// Stage two shifts the count by the pair's bit weight and adds or
// subtracts it into a 32-bit accumulator, flagging the final term.

`timescale 1ns/1ns

module vvp_shacc import mvu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clr,                 // Clear the accumulator
    input  logic               valid,
    input  logic               last,
    input  logic               neg,                 // Subtract this term
    input  logic [SHIFT_W-1:0] shift,
    input  logic [N_LANES-1:0] d_word,
    input  logic [N_LANES-1:0] w_word,
    output logic [ACC_W-1:0]   acc,
    output logic               acc_done
);

    logic [N_LANES-1:0] and_word;
    logic [CNT_W-1:0]   popcnt;
    logic [CNT_W-1:0]   cnt_q;                      // Stage one payload
    logic [SHIFT_W-1:0] shift_q;
    logic               neg_q;
    logic               valid_q;
    logic               last_q;
    logic [ACC_W-1:0]   term;

    assign and_word = d_word & w_word;              // 1-bit products per lane

    always_comb begin
        popcnt = '0;
        for (int k = 0; k < N_LANES; k++) begin
            popcnt = popcnt + CNT_W'(and_word[k]);
        end
    end

    always_ff @(posedge clk) begin
        cnt_q   <= popcnt;
        shift_q <= shift;
        neg_q   <= neg;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= valid;
            last_q  <= valid & last;                // Ignore last outside a walk
        end
    end

    assign term = ACC_W'(cnt_q) << shift_q;         // Scale by 2^(wbit+ibit)

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc      <= '0;
            acc_done <= 1'b0;
        end else begin
            acc_done <= last_q;                     // Final term lands this edge
            if (clr) begin
                acc <= '0;
            end else if (valid_q) begin
                acc <= neg_q ? acc - term : acc + term; // MSB planes carry negative weight
            end
        end
    end

    // Bit positions from the AGU must fit the precision range
    a_shift_range: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> (shift <= SHIFT_W'(2 * ((1 << PREC_W) - 1))));

endmodule

// File: src/mvu_top.sv
// Bit-serial dot product engine, top level
// Holds the job configuration latched at start, the two bit-plane banks,
// the address walk and the AND-popcount shift-accumulate pipeline.
// Result appears on acc_out together with done and irq.

`timescale 1ns/1ns

module mvu_top import mvu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   d_signed,        // Input data two's complement
    input  logic                   w_signed,        // Weights two's complement
    input  logic [PREC_W-1:0]      iprec,           // Input bits minus 1
    input  logic [PREC_W-1:0]      wprec,           // Weight bits minus 1
    input  logic [BANK_ADDR_W-1:0] ibase,           // Input plane 0 address
    input  logic [BANK_ADDR_W-1:0] wbase,           // Weight plane 0 address
    input  logic                   wr_d_en,
    input  logic                   wr_w_en,
    input  logic [BANK_ADDR_W-1:0] wr_d_addr,
    input  logic [BANK_ADDR_W-1:0] wr_w_addr,
    input  logic [N_LANES-1:0]     wr_d_word,
    input  logic [N_LANES-1:0]     wr_w_word,
    output logic                   busy,
    output logic                   done,
    output logic                   irq,
    output logic [ACC_W-1:0]       acc_out
);

    // Latched job configuration
    logic                   d_signed_q;
    logic                   w_signed_q;
    logic [PREC_W-1:0]      iprec_q;
    logic [PREC_W-1:0]      wprec_q;
    logic [BANK_ADDR_W-1:0] ibase_q;
    logic [BANK_ADDR_W-1:0] wbase_q;

    logic                    cfg_load;
    logic                    agu_en;
    logic                    agu_last;
    logic                    acc_done;
    logic [BANK_ADDR_W-1:0]  waddr;
    logic [BANK_ADDR_W-1:0]  iaddr;
    logic                    w_msb;
    logic                    i_msb;
    logic [SHIFT_W-1:0]      shift;
    logic                    neg;
    logic [CTRL_FLAGS_W-1:0] flags_in;
    logic [CTRL_FLAGS_W-1:0] flags_out;             // Aligned with the read data
    logic                    neg_d;
    logic [SHIFT_W-1:0]      shift_d;
    logic                    valid_d;
    logic                    last_d;
    logic [N_LANES-1:0]      d_word;
    logic [N_LANES-1:0]      w_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_signed_q <= 1'b0;
            w_signed_q <= 1'b0;
            iprec_q    <= '0;
            wprec_q    <= '0;
            ibase_q    <= '0;
            wbase_q    <= '0;
        end else if (cfg_load) begin
            d_signed_q <= d_signed;
            w_signed_q <= w_signed;
            iprec_q    <= iprec;
            wprec_q    <= wprec;
            ibase_q    <= ibase;
            wbase_q    <= wbase;
        end
    end

    mvu_controller u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .agu_last (agu_last),
        .acc_done (acc_done),
        .cfg_load (cfg_load),
        .agu_en   (agu_en),
        .busy     (busy),
        .done     (done),
        .irq      (irq)
    );

    mvu_agu u_agu (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (cfg_load),
        .en    (agu_en),
        .wprec (wprec_q),
        .iprec (iprec_q),
        .wbase (wbase_q),
        .ibase (ibase_q),
        .waddr (waddr),
        .iaddr (iaddr),
        .w_msb (w_msb),
        .i_msb (i_msb),
        .last  (agu_last),
        .shift (shift)
    );

    // MSB plane of a signed operand has weight -2^msb
    assign neg      = (d_signed_q & i_msb) ^ (w_signed_q & w_msb);
    assign flags_in = {neg, shift, agu_en, agu_last};
    assign {neg_d, shift_d, valid_d, last_d} = flags_out;

    bitplane_bank data_bank (
        .clk     (clk),
        .wr_en   (wr_d_en),
        .wr_addr (wr_d_addr),
        .rd_addr (iaddr),
        .wr_word (wr_d_word),
        .rd_word (d_word)
    );

    bitplane_bank weight_bank (
        .clk     (clk),
        .wr_en   (wr_w_en),
        .wr_addr (wr_w_addr),
        .rd_addr (waddr),
        .wr_word (wr_w_word),
        .rd_word (w_word)
    );

    ctrl_delay #(
        .DEPTH (MEM_RD_LATENCY)
    ) u_flag_dly (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flags  (flags_in),
        .out_flags (flags_out)
    );

    vvp_shacc u_shacc (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr      (cfg_load),                       // Result held until next job
        .valid    (valid_d),
        .last     (last_d),
        .neg      (neg_d),
        .shift    (shift_d),
        .d_word   (d_word),
        .w_word   (w_word),
        .acc      (acc_out),
        .acc_done (acc_done)
    );

endmodule

// File: tests/mvu_tb.sv
// Testbench for the bit-serial dot product engine
// Writes bit-plane vectors into both banks and runs directed and random
// jobs. Each result and done time is checked against a dot product model.

`timescale 1ns/1ns

module mvu_tb import mvu_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES   = RESET_CYCLES + 40 * (256 + 10); // 40 jobs of at most 16x16 bits

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic                   d_signed;
    logic                   w_signed;
    logic [PREC_W-1:0]      iprec;
    logic [PREC_W-1:0]      wprec;
    logic [BANK_ADDR_W-1:0] ibase;
    logic [BANK_ADDR_W-1:0] wbase;
    logic                   wr_d_en;
    logic                   wr_w_en;
    logic [BANK_ADDR_W-1:0] wr_d_addr;
    logic [BANK_ADDR_W-1:0] wr_w_addr;
    logic [N_LANES-1:0]     wr_d_word;
    logic [N_LANES-1:0]     wr_w_word;
    logic                   busy;
    logic                   done;
    logic                   irq;
    logic [ACC_W-1:0]       acc_out;

    int          seed = 2;                          // Fixed seed for $random
    int          cycle_cnt;
    int          jobs_run;                          // Completed jobs
    logic [15:0] d_raw [N_LANES];                   // Element bit patterns, masked by precision
    logic [15:0] w_raw [N_LANES];

    mvu_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .d_signed  (d_signed),
        .w_signed  (w_signed),
        .iprec     (iprec),
        .wprec     (wprec),
        .ibase     (ibase),
        .wbase     (wbase),
        .wr_d_en   (wr_d_en),
        .wr_w_en   (wr_w_en),
        .wr_d_addr (wr_d_addr),
        .wr_w_addr (wr_w_addr),
        .wr_d_word (wr_d_word),
        .wr_w_word (wr_w_word),
        .busy      (busy),
        .done      (done),
        .irq       (irq),
        .acc_out   (acc_out)
    );

    always #4 clk = ~clk;                           // 8 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $fatal(1, "simulation ran past its cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: time %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Element value from its low prec+1 bits, MSB weighs -2^prec when signed
    function automatic longint elem_value(input logic [15:0] raw, input int prec,
                                          input logic sgn);
        longint v;
        v = 0;
        for (int b = 0; b <= prec; b++) begin
            if (raw[b]) v = v + (longint'(1) << b);
        end
        if (sgn && raw[prec]) v = v - (longint'(1) << (prec + 1));
        return v;
    endfunction

    function automatic longint dot_model(input int in_prec, input int wt_prec,
                                         input logic d_sgn, input logic w_sgn);
        longint sum;
        sum = 0;
        for (int k = 0; k < N_LANES; k++) begin
            sum = sum + elem_value(d_raw[k], in_prec, d_sgn)
                      * elem_value(w_raw[k], wt_prec, w_sgn);
        end
        return sum;
    endfunction

    // Plane b holds bit b of every element, one word per plane
    task automatic load_vectors(input logic [BANK_ADDR_W-1:0] in_base,
                                input logic [BANK_ADDR_W-1:0] wt_base,
                                input int in_prec, input int wt_prec);
        logic [N_LANES-1:0] d_plane;
        logic [N_LANES-1:0] w_plane;
        int                 top_bit;
        top_bit = (in_prec > wt_prec) ? in_prec : wt_prec;
        for (int b = 0; b <= top_bit; b++) begin
            for (int k = 0; k < N_LANES; k++) begin
                d_plane[k] = d_raw[k][b];
                w_plane[k] = w_raw[k][b];
            end
            @(posedge clk);
            wr_d_en   <= (b <= in_prec);
            wr_w_en   <= (b <= wt_prec);
            wr_d_addr <= in_base + BANK_ADDR_W'(b); // Wraps like the AGU address
            wr_w_addr <= wt_base + BANK_ADDR_W'(b);
            wr_d_word <= d_plane;
            wr_w_word <= w_plane;
        end
        @(posedge clk);
        wr_d_en <= 1'b0;
        wr_w_en <= 1'b0;
    endtask

    // Pulses start, optionally repeats it while busy, counts cycles up to done
    task automatic run_job(input int extra_start, output int cycles);
        @(negedge clk);
        if (jobs_run > 0) check_value("irq", 64'(irq), 64'd1);  // Still up from last job
        @(posedge clk);
        start  <= 1'b1;
        @(posedge clk);                                 // Start edge, DUT samples start
        start  <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            start <= (extra_start > 0) && (cycles == extra_start);
            @(negedge clk);
            if (cycles == 1) begin
                check_value("busy", 64'(busy), 64'd1);
                check_value("irq", 64'(irq), 64'd0);    // Cleared by the new job
            end
        end while (!done);
        check_value("irq", 64'(irq), 64'd1);
        check_value("busy", 64'(busy), 64'd0);
        @(negedge clk);
        check_value("done", 64'(done), 64'd0);          // Single-cycle pulse
        check_value("irq", 64'(irq), 64'd1);
        check_value("busy", 64'(busy), 64'd0);          // Extra start left no job behind
        jobs_run++;
    endtask

    task automatic do_job(input logic [BANK_ADDR_W-1:0] in_base,
                          input logic [BANK_ADDR_W-1:0] wt_base,
                          input int in_prec, input int wt_prec,
                          input logic d_sgn, input logic w_sgn, input int extra_start);
        longint expected;
        int     cycles;
        load_vectors(in_base, wt_base, in_prec, wt_prec);
        expected = dot_model(in_prec, wt_prec, d_sgn, w_sgn);
        @(posedge clk);
        ibase    <= in_base;
        wbase    <= wt_base;
        iprec    <= PREC_W'(in_prec);
        wprec    <= PREC_W'(wt_prec);
        d_signed <= d_sgn;
        w_signed <= w_sgn;
        run_job(extra_start, cycles);
        check_value("acc_out", 64'(acc_out), 64'(expected[31:0]));   // Wraps at 32 bits
        check_value("done_cycles", 64'(cycles), 64'((in_prec + 1) * (wt_prec + 1) + 4));
    endtask

    task automatic check_reset_state();
        check_value("busy", 64'(busy), 64'd0);
        check_value("done", 64'(done), 64'd0);
        check_value("irq", 64'(irq), 64'd0);
        check_value("acc_out", 64'(acc_out), 64'd0);
    endtask

    task automatic unsigned_jobs();
        for (int k = 0; k < N_LANES; k++) begin
            d_raw[k] = 16'(k + 9);
            w_raw[k] = 16'(15 - k);
        end
        do_job(6'd0, 6'd0, 3, 3, 1'b0, 1'b0, 0);        // 4x4 bits
        for (int k = 0; k < N_LANES; k++) begin
            d_raw[k] = 16'(k * 9 + 5);
            w_raw[k] = 16'(3 * k + 1);
        end
        do_job(6'd10, 6'd20, 5, 2, 1'b0, 1'b0, 0);      // 6-bit inputs, 3-bit weights
    endtask

    task automatic signed_jobs();
        for (int k = 0; k < N_LANES; k++) begin
            d_raw[k] = 16'(k * 3 - 8);                  // Starts at the 4-bit minimum
            w_raw[k] = 16'(k + 1);
        end
        do_job(6'd32, 6'd40, 3, 3, 1'b1, 1'b0, 0);
        for (int k = 0; k < N_LANES; k++) begin
            d_raw[k] = 16'(k);
            w_raw[k] = 16'(7 - 2 * k);
        end
        w_raw[3] = 16'h0020;                            // 6-bit minimum, -32
        do_job(6'd5, 6'd50, 2, 5, 1'b0, 1'b1, 0);
        for (int k = 0; k < N_LANES; k++) begin
            d_raw[k] = 16'(-128 + 37 * k);
            w_raw[k] = (k % 2 == 1) ? 16'hff80 : 16'(127 - 20 * k);
        end
        do_job(6'd16, 6'd16, 7, 7, 1'b1, 1'b1, 0);      // Both 8-bit signed
    endtask

    task automatic random_jobs();
        int                     in_prec;
        int                     wt_prec;
        logic                   d_sgn;
        logic                   w_sgn;
        logic [BANK_ADDR_W-1:0] in_base;
        logic [BANK_ADDR_W-1:0] wt_base;
        for (int n = 0; n < 30; n++) begin
            for (int k = 0; k < N_LANES; k++) begin
                d_raw[k] = 16'($random(seed));
                w_raw[k] = 16'($random(seed));
            end
            in_prec = $random(seed) & 15;
            wt_prec = $random(seed) & 15;
            d_sgn   = 1'($random(seed));
            w_sgn   = 1'($random(seed));
            in_base = BANK_ADDR_W'($random(seed));
            wt_base = BANK_ADDR_W'($random(seed));
            do_job(in_base, wt_base, in_prec, wt_prec, d_sgn, w_sgn, 0);
        end
    endtask

    task automatic restart_while_busy();
        for (int k = 0; k < N_LANES; k++) begin
            d_raw[k] = 16'(5 * k - 7);
            w_raw[k] = 16'(11 - 3 * k);
        end
        do_job(6'd48, 6'd8, 3, 3, 1'b1, 1'b1, 5);       // Second start mid-run
        do_job(6'd48, 6'd8, 3, 3, 1'b1, 1'b1, 0);       // Same job, same result and timing
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        d_signed  = 1'b0;
        w_signed  = 1'b0;
        iprec     = '0;
        wprec     = '0;
        ibase     = '0;
        wbase     = '0;
        wr_d_en   = 1'b0;
        wr_w_en   = 1'b0;
        wr_d_addr = '0;
        wr_w_addr = '0;
        wr_d_word = '0;
        wr_w_word = '0;
        cycle_cnt = 0;
        jobs_run  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_state();
        unsigned_jobs();
        signed_jobs();
        random_jobs();
        restart_while_busy();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: list.f
src/mvu_pkg.sv
src/mvu_controller.sv
src/mvu_agu.sv
src/bitplane_bank.sv
src/ctrl_delay.sv
src/vvp_shacc.sv
src/mvu_top.sv
tests/mvu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the dot product engine testbench with Verilator.
# The result is taken from the simulation log.

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module mvu_tb -Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vmvu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Testbench passed$" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
